// ==== files.f ====
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/inst_ram.sv
hdl/if_stage.sv
hdl/apb_imem_port.sv
hdl/fetch_top.sv
testbench/fetch_asserts.sv
testbench/fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f files.f --top-module fetch_tb \
	--Mdir obj_dir -o fetch_sim

./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	exit 1
fi
grep -q "ALL TESTS PASSED" sim.log

// ==== testbench/fetch_tb.sv ====
// testbench for fetch_top: APB refill and readback, sequential fetch, stalls and redirects
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_tb;
	import fetch_pkg::*;
	import rv_isa_pkg::*;

	logic clk;
	logic rst_n;
	apb_req_t apb;
	apb_rsp_t apb_rsp;
	logic pc_start;
	logic [29:0] start_adr;
	logic stall;
	redirect_t redir;
	if_id_t if_id;

	logic [31:0] shadow [2**`FETCH_IWIDTH];
	logic [15:0] lfsr = 16'd91;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	// reference model state
	logic [29:0] m_pc;
	logic        m_run;
	logic        m_trap_q;
	if_id_t      exp;
	logic        exp_chk;  // inst is known

	fetch_top u_fetch_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_apb       (apb),
		.o_apb       (apb_rsp),
		.i_pc_start  (pc_start),
		.i_start_adr (start_adr),
		.i_stall     (stall),
		.i_redirect  (redir),
		.o_if_id     (if_id)
	);

	bind fetch_top fetch_asserts u_fetch_asserts (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_apb      (i_apb),
		.i_apb_rsp  (o_apb),
		.i_pc_start (i_pc_start),
		.i_redirect (i_redirect),
		.i_if_id    (o_if_id)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// 16 bit fibonacci, taps 16 14 13 11
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			v    = {v[30:0], lfsr[15]};
			lfsr = {lfsr[14:0], fb};
		end
		return v;
	endfunction

	function automatic logic redirect_taken(input redirect_t r, input logic trap_q);
		return r.trap | ((r.mret | r.jump) & ~trap_q);
	endfunction

	// next pc: start, then trap > mret > jump, then stall hold, then +1 when running
	function automatic logic [29:0] ref_next_pc(input logic [29:0] pc, input logic run,
			input logic stall_in, input logic start, input logic [29:0] sadr,
			input redirect_t r, input logic trap_q);
		if (start)
			return sadr;
		if (redirect_taken(r, trap_q))
			return r.trap ? r.mtvec : (r.mret ? r.mepc : r.jump_adr);
		if (!stall_in && run)
			return pc + 30'd1;
		return pc;
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_pc     = `FETCH_RESET_PC;
			m_run    = 1'b0;
			m_trap_q = 1'b0;
			exp      = '{valid: 1'b0, pc: 30'd0, inst: RV_NOP};
			exp_chk  = 1'b0;
		end else begin
			if (pc_start || redirect_taken(redir, m_trap_q)) begin
				exp     = '{valid: 1'b0, pc: m_pc, inst: RV_NOP};
				exp_chk = 1'b1;
			end else if (!stall) begin
				exp     = '{valid: m_run, pc: m_pc, inst: shadow[m_pc[`FETCH_IWIDTH-1:0]]};
				exp_chk = m_run;
			end // stalled output holds
			m_pc     = ref_next_pc(m_pc, m_run, stall, pc_start, start_adr, redir, m_trap_q);
			m_run    = m_run | pc_start;
			m_trap_q = redir.trap;
		end
	end

	task automatic check_equal(input string name, input logic [31:0] e, input logic [31:0] g);
		checks++;
		assert (g === e) else begin
			errors++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, e, g);
		end
	endtask

	// compare mid-cycle, away from the clock edge
	always @(negedge clk) begin
		if (rst_n) begin
			check_equal("o_if_id.valid", exp.valid, if_id.valid);
			if (exp.valid)
				check_equal("o_if_id.pc", exp.pc, if_id.pc);
			if (exp_chk)
				check_equal("o_if_id.inst", exp.inst, if_id.inst);
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= 4000) begin
			$display("timeout: run did not finish within 4000 cycles");
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic apb_write(input logic [15:0] adr, input logic [31:0] d);
		@(posedge clk); #1;
		apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: adr, pwdata: d};
		@(posedge clk); #1;
		apb.penable = 1'b1;
		@(negedge clk);
		while (!apb_rsp.pready) @(negedge clk);
		@(posedge clk); #1;
		apb = '0;
	endtask

	task automatic apb_read(input logic [15:0] adr, output logic [31:0] d, output logic err);
		@(posedge clk); #1;
		apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: adr, pwdata: 32'd0};
		@(posedge clk); #1;
		apb.penable = 1'b1;
		@(negedge clk);
		while (!apb_rsp.pready) @(negedge clk);
		d   = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		@(posedge clk); #1;
		apb = '0;
	endtask

	task automatic refill_line(input int idx, input logic [3:0][31:0] words);
		for (int k = 0; k < 4; k++)
			apb_write(16'(idx * 16 + k * 4), words[k]);
		for (int k = 0; k < 4; k++)
			shadow[idx * 4 + k] = words[k];
	endtask

	task automatic start_fetch(input logic [29:0] adr);
		@(posedge clk); #1;
		pc_start  = 1'b1;
		start_adr = adr;
		@(posedge clk); #1;
		pc_start = 1'b0;
	endtask

	task automatic drive_redirect(input redirect_t r);
		@(posedge clk); #1;
		redir = r;
		@(posedge clk); #1;
		redir = '0;
	endtask

	task automatic run_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	initial begin
		logic [3:0][31:0] words;
		logic [31:0] rd;
		logic err;
		redirect_t r;
		rst_n = 1'b0;
		apb = '0;
		pc_start = 1'b0;
		start_adr = '0;
		stall = 1'b0;
		redir = '0;
		repeat (5) @(posedge clk);
		#1 rst_n = 1'b1;

		// refill 64 lines and read every word back
		for (int l = 0; l < 64; l++) begin
			for (int k = 0; k < 4; k++) begin
				rd       = lfsr_bits(25);
				words[k] = {rd[24:0], OP_OP};
			end
			refill_line(l, words);
		end
		for (int a = 0; a < 256; a++) begin
			apb_read(16'(a * 4), rd, err);
			check_equal("prdata", shadow[a], rd);
			check_equal("pslverr", 32'd0, {31'd0, err});
		end
		apb_read(16'h1000, rd, err);
		check_equal("pslverr", 32'd1, {31'd0, err});

		// sequential fetch from 0
		start_fetch(30'd0);
		run_cycles(40);

		// random stalls
		r = '0;
		r.jump = 1'b1;
		r.jump_adr = 30'd0;
		drive_redirect(r);
		repeat (200) begin
			@(posedge clk); #1;
			rd    = lfsr_bits(1);
			stall = rd[0];
		end
		@(posedge clk); #1;
		stall = 1'b0;

		// redirect priority
		r = '{trap: 1'b1, mret: 1'b1, jump: 1'b1, jump_adr: 30'd20, mtvec: 30'd100, mepc: 30'd150};
		drive_redirect(r);
		run_cycles(5);
		r.trap = 1'b0;
		drive_redirect(r);
		run_cycles(5);
		r.mret = 1'b0;
		drive_redirect(r);
		run_cycles(5);
		#1 stall = 1'b1; // redirect under stall
		drive_redirect(r);
		stall = 1'b0;
		run_cycles(5);

		// mret or jump right after a trap is ignored
		r = '{trap: 1'b1, mret: 1'b0, jump: 1'b0, jump_adr: 30'd200, mtvec: 30'd60, mepc: 30'd180};
		@(posedge clk); #1;
		redir = r;
		@(posedge clk); #1;
		redir = '{trap: 1'b0, mret: 1'b0, jump: 1'b1, jump_adr: 30'd200, mtvec: 30'd60, mepc: 30'd0};
		@(posedge clk); #1;
		redir = '{trap: 1'b1, mret: 1'b0, jump: 1'b0, jump_adr: 30'd0, mtvec: 30'd70, mepc: 30'd180};
		@(posedge clk); #1;
		redir = '{trap: 1'b0, mret: 1'b1, jump: 1'b0, jump_adr: 30'd0, mtvec: 30'd0, mepc: 30'd180};
		@(posedge clk); #1;
		redir = '0;
		run_cycles(6);

		// APB traffic while fetch runs, then fetch the rewritten line
		r = '0;
		r.jump = 1'b1;
		r.jump_adr = 30'd0;
		drive_redirect(r);
		for (int k = 0; k < 4; k++) begin
			rd       = lfsr_bits(25);
			words[k] = {rd[24:0], OP_JAL};
		end
		refill_line(60, words);
		apb_read(16'(5 * 4), rd, err);
		check_equal("prdata", shadow[5], rd);
		apb_read(16'(241 * 4), rd, err);
		check_equal("prdata", shadow[241], rd);
		r.jump_adr = 30'd238;
		drive_redirect(r);
		run_cycles(10);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== testbench/fetch_asserts.sv ====
// concurrent protocol checks for the fetch subsystem, bound into fetch_top by the testbench
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_asserts (
	input logic                 clk,
	input logic                 rst_n,
	input fetch_pkg::apb_req_t  i_apb,
	input fetch_pkg::apb_rsp_t  i_apb_rsp,
	input logic                 i_pc_start,
	input fetch_pkg::redirect_t i_redirect,
	input fetch_pkg::if_id_t    i_if_id
);
	import rv_isa_pkg::*;

	logic seen_start;
	logic trap_q;  // mret or jump after a trap is dropped
	logic accepted;
	logic rd_access; // read in its access phase

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			seen_start <= 1'b0;
			trap_q     <= 1'b0;
		end else begin
			seen_start <= seen_start | i_pc_start;
			trap_q     <= i_redirect.trap;
		end
	end

	assign accepted = i_pc_start | i_redirect.trap |
		((i_redirect.mret | i_redirect.jump) & ~trap_q);

	assign rd_access = i_apb.psel & i_apb.penable & ~i_apb.pwrite;

	a_idle_invalid: assert property (@(posedge clk) disable iff (!rst_n)
		!seen_start |-> !i_if_id.valid)
		else $error("fetch output valid before any start");

	a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		accepted |=> (!i_if_id.valid && i_if_id.inst == RV_NOP))
		else $error("no bubble after an accepted redirect");

	// one wait state for the RAM read
	a_rd_wait: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(rd_access) |-> !i_apb_rsp.pready)
		else $error("APB read ready in its first access cycle");

	a_rd_ready: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(rd_access) |=> i_apb_rsp.pready)
		else $error("APB read not ready in its second access cycle");

endmodule

// ==== hdl/fetch_top.sv ====
// top of the fetch subsystem, joins the fetch stage and the APB refill and readback port
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  fetch_pkg::apb_req_t  i_apb,
	output fetch_pkg::apb_rsp_t  o_apb,
	input  logic                 i_pc_start,
	input  logic [29:0]          i_start_adr,
	input  logic                 i_stall,
	input  fetch_pkg::redirect_t i_redirect,
	output fetch_pkg::if_id_t    o_if_id
);
	import fetch_pkg::*;

	line_wr_t                 line;     // refill from APB into the RAM
	logic [`FETCH_IWIDTH-1:0] mon_adr;
	logic [31:0]              mon_data;

	if_stage u_if_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_start     (i_pc_start),
		.i_start_adr (i_start_adr),
		.i_stall     (i_stall),
		.i_redirect  (i_redirect),
		.i_line      (line),
		.i_mon_adr   (mon_adr),
		.o_mon_data  (mon_data),
		.o_if_id     (o_if_id)
	);

	apb_imem_port u_apb_imem_port (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_apb      (i_apb),
		.o_apb      (o_apb),
		.o_line     (line),
		.o_mon_adr  (mon_adr),
		.i_mon_data (mon_data)
	);

endmodule

// ==== hdl/apb_imem_port.sv ====
// APB slave for the monitor: four word writes refill one RAM line, reads return one word
`timescale 1ns/1ps
`include "fetch_config.svh"

module apb_imem_port (
	input  logic                     clk,
	input  logic                     rst_n,
	input  fetch_pkg::apb_req_t      i_apb,
	output fetch_pkg::apb_rsp_t      o_apb,
	output fetch_pkg::line_wr_t      o_line,
	output logic [`FETCH_IWIDTH-1:0] o_mon_adr,
	input  logic [31:0]              i_mon_data
);
	import fetch_pkg::*;

	apb_state_e state;
	logic             access;
	logic             range_err;
	logic             wr_ok;
	logic             ready;
	logic [3:0][31:0] stage;      // staged refill words
	logic             line_go_q;
	logic [`FETCH_IWIDTH-3:0] line_idx_q;

	assign access    = i_apb.psel & i_apb.penable;
	assign range_err = |i_apb.paddr[`FETCH_APB_AW-1:`FETCH_IWIDTH+2];
	assign wr_ok     = access & i_apb.pwrite & ~range_err;

	// writes end in the first access cycle, reads wait one for the RAM
	assign ready = access & (i_apb.pwrite | (state == RD_WAIT));

	assign o_apb = '{
		pready:  ready,
		prdata:  (state == RD_WAIT && !range_err) ? i_mon_data : 32'd0,
		pslverr: ready & range_err
	};

	assign o_mon_adr = i_apb.paddr[`FETCH_IWIDTH+1:2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= SETUP;
			line_go_q <= 1'b0;
		end else begin
			line_go_q <= wr_ok & (i_apb.paddr[3:2] == 2'd3); // last word of the line
			case (state)
				SETUP:   if (access && !i_apb.pwrite) state <= RD_WAIT;
				RD_WAIT: state <= SETUP;
				default: state <= SETUP;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			stage[i_apb.paddr[3:2]] <= i_apb.pwdata;
			line_idx_q <= i_apb.paddr[`FETCH_IWIDTH+1:4];
		end
	end

	assign o_line = '{wen: line_go_q, idx: line_idx_q, data: stage};

endmodule

// ==== hdl/if_stage.sv ====
// fetch stage: PC, instruction RAM read, stall hold and bubble insertion in front of IF/ID
`timescale 1ns/1ps
`include "fetch_config.svh"

module if_stage (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     i_start,
	input  logic [29:0]              i_start_adr,
	input  logic                     i_stall,
	input  fetch_pkg::redirect_t     i_redirect,
	input  fetch_pkg::line_wr_t      i_line,
	input  logic [`FETCH_IWIDTH-1:0] i_mon_adr,
	output logic [31:0]              o_mon_data,
	output fetch_pkg::if_id_t        o_if_id
);
	import fetch_pkg::*;
	import rv_isa_pkg::*;

	logic [29:0] pc;
	logic        kill;
	logic [29:0] pc_q;       // pc of the word leaving the RAM
	logic [31:0] fetch_data;
	logic        started_q;
	logic        stall_q;
	if_id_t      hold_q;
	if_id_t      live;
	if_id_t      bubble;

	pc_gen u_pc_gen (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_start     (i_start),
		.i_start_adr (i_start_adr),
		.i_stall     (i_stall),
		.i_redirect  (i_redirect),
		.o_pc        (pc),
		.o_kill      (kill)
	);

	inst_ram #(.IWIDTH(`FETCH_IWIDTH)) u_inst_ram (
		.clk          (clk),
		.i_line       (i_line),
		.i_fetch_adr  (pc[`FETCH_IWIDTH-1:0]),
		.o_fetch_data (fetch_data),
		.i_mon_adr    (i_mon_adr),
		.o_mon_data   (o_mon_data)
	);

	always_ff @(posedge clk) begin
		pc_q <= pc; // follows the synchronous read
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			started_q <= 1'b0;
			stall_q   <= 1'b0;
			hold_q    <= '{valid: 1'b0, pc: 30'd0, inst: RV_NOP};
		end else begin
			started_q <= started_q | i_start;
			stall_q   <= i_stall;
			hold_q    <= o_if_id; // recirculates while held
		end
	end

	assign live   = '{valid: started_q, pc: pc_q, inst: fetch_data};
	assign bubble = '{valid: 1'b0, pc: pc_q, inst: RV_NOP};

	// a kill beats the hold so a redirect under stall is not lost
	assign o_if_id = kill ? bubble : (stall_q ? hold_q : live);

endmodule

// ==== hdl/inst_ram.sv ====
// instruction RAM, refilled one 128-bit line per write, with a fetch read port and a monitor read port
`timescale 1ns/1ps
`include "fetch_config.svh"

module inst_ram #(
	parameter int IWIDTH = `FETCH_IWIDTH
) (
	input  logic                clk,
	input  fetch_pkg::line_wr_t i_line,
	input  logic [IWIDTH-1:0]   i_fetch_adr,
	output logic [31:0]         o_fetch_data,
	input  logic [IWIDTH-1:0]   i_mon_adr,
	output logic [31:0]         o_mon_data
);

	localparam int LINES = 2 ** (IWIDTH - 2);

	// stored as lines so a refill is a single write port
	logic [3:0][31:0] mem [LINES];

	logic [IWIDTH-3:0] fetch_line;
	logic [1:0]        fetch_word;
	logic [IWIDTH-3:0] mon_line;
	logic [1:0]        mon_word;

	assign fetch_line = i_fetch_adr[IWIDTH-1:2];
	assign fetch_word = i_fetch_adr[1:0];
	assign mon_line   = i_mon_adr[IWIDTH-1:2];
	assign mon_word   = i_mon_adr[1:0];

	always_ff @(posedge clk) begin
		if (i_line.wen)
			mem[i_line.idx] <= i_line.data;
	end

	// both reads see the old line on a same-cycle write
	always_ff @(posedge clk) begin
		o_fetch_data <= mem[fetch_line][fetch_word];
	end

	always_ff @(posedge clk) begin
		o_mon_data <= mem[mon_line][mon_word]; // monitor port, independent of fetch
	end

endmodule

// ==== hdl/pc_gen.sv ====
// program counter of the fetch stage with start, stall hold and trap/mret/jump redirect
`timescale 1ns/1ps
`include "fetch_config.svh"

module pc_gen (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_start,
	input  logic [29:0]          i_start_adr,
	input  logic                 i_stall,
	input  fetch_pkg::redirect_t i_redirect,
	output logic [29:0]          o_pc,
	output logic                 o_kill
);
	import fetch_pkg::*;

	fetch_state_e state;
	logic [29:0] pc_q;
	logic        trap_q;     // trap seen last cycle
	logic        redir_take;
	logic [29:0] redir_adr;

	// mret and jump right after a trap belong to the flushed path
	assign redir_take = i_redirect.trap |
		((i_redirect.mret | i_redirect.jump) & ~trap_q);

	always_comb begin
		if (i_redirect.trap)
			redir_adr = i_redirect.mtvec;
		else if (i_redirect.mret)
			redir_adr = i_redirect.mepc;
		else
			redir_adr = i_redirect.jump_adr;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= IDLE;
			pc_q   <= `FETCH_RESET_PC;
			trap_q <= 1'b0;
			o_kill <= 1'b0;
		end else begin
			trap_q <= i_redirect.trap;
			o_kill <= i_start | redir_take; // word in flight is wrong path
			if (i_start) begin
				state <= RUN;
				pc_q  <= i_start_adr;
			end else if (redir_take) begin
				pc_q <= redir_adr;  // taken even under stall
			end else if (!i_stall && state == RUN) begin
				pc_q <= pc_q + 30'd1;
			end
		end
	end

	assign o_pc = pc_q;

endmodule

// ==== hdl/fetch_pkg.sv ====
// pipeline and bus types of the fetch subsystem: redirect request, IF/ID payload, APB, line write
`include "fetch_config.svh"

package fetch_pkg;

	typedef struct packed {
		logic        trap;     // highest priority, goes to mtvec
		logic        mret;     // back to mepc
		logic        jump;     // jal, jalr, taken branch
		logic [29:0] jump_adr;
		logic [29:0] mtvec;
		logic [29:0] mepc;
	} redirect_t;

	typedef struct packed {
		logic        valid;
		logic [29:0] pc;   // word address
		logic [31:0] inst;
	} if_id_t;

	typedef struct packed {
		logic                     psel;
		logic                     penable;
		logic                     pwrite;
		logic [`FETCH_APB_AW-1:0] paddr;
		logic [31:0]              pwdata;
	} apb_req_t;

	typedef struct packed {
		logic        pready;
		logic [31:0] prdata;
		logic        pslverr;
	} apb_rsp_t;

	typedef struct packed {
		logic                     wen;
		logic [`FETCH_IWIDTH-3:0] idx;  // line index
		logic [3:0][31:0]         data; // word k in bits 32k+31:32k
	} line_wr_t;

	typedef enum logic {IDLE, RUN} fetch_state_e;

	typedef enum logic {SETUP, RD_WAIT} apb_state_e;

endpackage

// ==== hdl/rv_isa_pkg.sv ====
// RV32I major opcodes and the bubble word, imported by the fetch RTL and the testbench
package rv_isa_pkg;

	// major opcode field, inst[6:0]
	typedef enum logic [6:0] {
		OP_LOAD     = 7'b0000011,
		OP_MISC_MEM = 7'b0001111,
		OP_IMM      = 7'b0010011,
		OP_AUIPC    = 7'b0010111,
		OP_STORE    = 7'b0100011,
		OP_OP       = 7'b0110011,
		OP_LUI      = 7'b0110111,
		OP_BRANCH   = 7'b1100011,
		OP_JALR     = 7'b1100111,
		OP_JAL      = 7'b1101111,
		OP_SYSTEM   = 7'b1110011
	} rv_opcode_e;

	// addi x0,x0,0
	// imm, rs1, funct3, rd all zero
	localparam logic [31:0] RV_NOP = {12'd0, 5'd0, 3'b000, 5'd0, OP_IMM};

endpackage

// ==== hdl/fetch_config.svh ====
// size and reset macros for the fetch subsystem, included by the RTL, the packages and the testbench
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// word address bits of the instruction RAM
// 10 bits gives 1024 words, 4 KB
`define FETCH_IWIDTH 10

// PC after reset, word address
// the fetch stage sits here in IDLE until a start
`define FETCH_RESET_PC 30'h0000_0000

// APB byte address width
// anything at or above 2^(FETCH_IWIDTH+2) is outside the RAM
`define FETCH_APB_AW 16

`endif
